// File: cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  // one data and address word on the bus
  typedef logic [31:0] word_t;

  // instruction layout: opcode in [31:28], operand address in [27:0]
  typedef enum logic [3:0] {
    op_nop   = 4'd0,
    op_load  = 4'd1,
    op_add   = 4'd2,
    op_store = 4'd3,
    op_jump  = 4'd4,
    op_halt  = 4'd5
  } opcode_e;

  typedef enum logic [1:0] {
    kind_fetch = 2'd0,  // instruction read
    kind_read  = 2'd1,  // data read
    kind_write = 2'd2
  } txn_kind_e;

  typedef enum logic [1:0] {
    st_idle  = 2'd0,
    st_fetch = 2'd1,
    st_exec  = 2'd2,
    st_halt  = 2'd3
  } core_state_e;

  localparam int table_depth = 32;  // entries in the transaction table
  localparam int index_w     = 5;   // width of a table index
  localparam int count_w     = 16;  // width of the matched transaction counter

endpackage

`default_nettype wire

// File: txn_table.sv
`timescale 1ns/1ps
`default_nettype none

module txn_table import cpu_pkg::*; (
  input  logic             clk,
  input  logic             reset,
  input  logic             load_en,
  input  logic [index_w-1:0] load_index,
  input  txn_kind_e        load_kind,
  input  word_t            load_addr,
  input  word_t            load_data,
  input  logic             count_en,
  input  logic [index_w:0] load_count,
  input  txn_kind_e        lookup_kind,
  input  word_t            lookup_addr,
  output logic             hit,
  output word_t            hit_data
);

  txn_kind_e        entry_kind [table_depth];
  word_t            entry_addr [table_depth];
  word_t            entry_data [table_depth];
  logic [index_w:0] valid_count;  // entries below this index take part in lookups

  // entry storage, written one entry per strobe
  always_ff @(posedge clk) begin
    if (load_en) begin
      entry_kind[load_index] <= load_kind;
      entry_addr[load_index] <= load_addr;
      entry_data[load_index] <= load_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_count <= '0;
    end else if (count_en) begin
      valid_count <= load_count;
    end
  end

  // Scanning upward and stopping at the first match gives the lowest index
  // priority when the same kind and address was loaded more than once.
  always_comb begin
    hit      = 1'b0;
    hit_data = '0;
    for (int i = 0; i < table_depth; i++) begin
      if (!hit && (i < int'(valid_count))) begin
        if ((entry_kind[i] == lookup_kind) && (entry_addr[i] == lookup_addr)) begin
          hit      = 1'b1;
          hit_data = entry_data[i];
        end
      end
    end
  end

  // an entry strobed in must land inside the table
  assert_load_index : assert property (
    @(posedge clk) disable iff (reset)
    load_en |-> (int'(load_index) < table_depth)
  ) else $error("txn_table: load_index %0d out of range", load_index);

  // a valid count past the table end would make lookups read unloaded entries
  assert_load_count : assert property (
    @(posedge clk) disable iff (reset)
    count_en |-> (int'(load_count) <= table_depth)
  ) else $error("txn_table: load_count %0d exceeds table depth", load_count);

endmodule

`default_nettype wire

// File: mock_mmu.sv
`timescale 1ns/1ps
`default_nettype none

module mock_mmu import cpu_pkg::*; (
  input  logic               clk,
  input  logic               reset,
  input  logic               cfg_en,
  input  word_t              cfg_boot_addr,
  input  word_t              cfg_boot_opcode,
  input  logic               read_en,
  input  logic               fetch,
  input  logic               write_en,
  input  word_t              addr,
  input  word_t              wdata,
  input  logic               hit,
  input  word_t              hit_data,
  output txn_kind_e          lookup_kind,
  output word_t              lookup_addr,
  output word_t              rdata,
  output logic               miss,
  output logic [count_w-1:0] txn_count
);

  word_t boot_addr;
  word_t boot_opcode;
  logic  access;
  logic  boot_hit;

  always_ff @(posedge clk) begin
    if (reset) begin
      boot_addr   <= '0;
      boot_opcode <= '0;
    end else if (cfg_en) begin
      boot_addr   <= cfg_boot_addr;
      boot_opcode <= cfg_boot_opcode;
    end
  end

  assign access   = read_en || write_en;
  assign boot_hit = read_en && (addr == boot_addr);  // boot word bypasses the table

  assign lookup_kind = write_en ? kind_write : (fetch ? kind_fetch : kind_read);
  assign lookup_addr = addr;

  always_comb begin
    rdata = '0;
    if (read_en) begin
      if (boot_hit) begin
        rdata = boot_opcode;
      end else if (hit) begin
        rdata = hit_data;
      end else if (fetch) begin
        rdata = addr;  // decodes as a nop since high bits of small addresses are zero
      end
    end
  end

  assign miss = access && !boot_hit && !hit;

  always_ff @(posedge clk) begin
    if (reset) begin
      txn_count <= '0;
    end else if (access && !boot_hit && hit) begin
      txn_count <= txn_count + 1'b1;
    end
  end

  // the fetch qualifier only makes sense on a read cycle
  assert_fetch_read : assert property (
    @(posedge clk) disable iff (reset)
    fetch |-> read_en
  ) else $error("mock_mmu: fetch without read_en at addr %h", addr);

  // the core must present settled store data whenever it writes
  assert_wdata_known : assert property (
    @(posedge clk) disable iff (reset)
    write_en |-> !$isunknown(wdata)
  ) else $error("mock_mmu: unknown write data at addr %h", addr);

endmodule

`default_nettype wire

// File: cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core import cpu_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  start,
  input  word_t rdata,
  output logic  read_en,
  output logic  fetch,
  output logic  write_en,
  output word_t addr,
  output word_t wdata,
  output logic  halted,
  output word_t acc
);

  core_state_e state;
  word_t       pc;
  word_t       ir;
  opcode_e     op;
  word_t       operand;

  assign op      = opcode_e'(ir[31:28]);
  assign operand = {4'd0, ir[27:0]};  // operand address is zero extended
  assign halted  = (state == st_halt);

  // bus requests follow directly from the state and the decoded instruction
  always_comb begin
    read_en  = 1'b0;
    fetch    = 1'b0;
    write_en = 1'b0;
    addr     = pc;
    wdata    = acc;
    case (state)
      st_fetch: begin
        read_en = 1'b1;
        fetch   = 1'b1;
      end
      st_exec: begin
        case (op)
          op_load, op_add: begin
            read_en = 1'b1;
            addr    = operand;
          end
          op_store: begin
            write_en = 1'b1;
            addr     = operand;
          end
          default: begin
            addr = pc;
          end
        endcase
      end
      default: begin
        addr = pc;
      end
    endcase
  end

  // instruction register is captured at the end of every fetch cycle
  always_ff @(posedge clk) begin
    if (state == st_fetch) begin
      ir <= rdata;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      pc    <= '0;
      acc   <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (start) begin
            state <= st_fetch;
            pc    <= '0;
          end
        end
        st_fetch: begin
          state <= st_exec;
        end
        st_exec: begin
          state <= st_fetch;
          pc    <= pc + 32'd1;  // nop and unknown opcodes only do this
          case (op)
            op_load: acc <= rdata;
            op_add:  acc <= acc + rdata;  // wraps at 32 bits
            op_jump: pc <= operand;
            op_halt: begin
              state <= st_halt;
              pc    <= pc;
            end
            default: begin
              acc <= acc;
            end
          endcase
        end
        default: begin
          state <= st_halt;  // only st_halt lands here, left by reset alone
        end
      endcase
    end
  end

  // the bus has a single direction per cycle
  assert_no_read_write : assert property (
    @(posedge clk) disable iff (reset)
    !(read_en && write_en)
  ) else $error("cpu_core: read_en and write_en high together at addr %h", addr);

endmodule

`default_nettype wire

// File: cpu_system_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_system_top import cpu_pkg::*; (
  input  logic               clk,
  input  logic               reset,
  input  logic               load_en,
  input  logic [index_w-1:0] load_index,
  input  txn_kind_e          load_kind,
  input  word_t              load_addr,
  input  word_t              load_data,
  input  logic               count_en,
  input  logic [index_w:0]   load_count,
  input  logic               cfg_en,
  input  word_t              cfg_boot_addr,
  input  word_t              cfg_boot_opcode,
  input  logic               start,
  output logic               halted,
  output word_t              acc,
  output logic               write_seen,
  output word_t              addr_out,
  output word_t              data_out,
  output logic               miss,
  output logic [count_w-1:0] txn_count
);

  logic      read_en;
  logic      fetch;
  logic      write_en;
  word_t     addr;
  word_t     wdata;
  word_t     rdata;
  txn_kind_e lookup_kind;
  word_t     lookup_addr;
  logic      hit;
  word_t     hit_data;

  // the write strobe and its address and data are visible outside for checking
  assign write_seen = write_en;
  assign addr_out   = addr;
  assign data_out   = wdata;

  cpu_core core_i (
    .clk      (clk),
    .reset    (reset),
    .start    (start),
    .rdata    (rdata),
    .read_en  (read_en),
    .fetch    (fetch),
    .write_en (write_en),
    .addr     (addr),
    .wdata    (wdata),
    .halted   (halted),
    .acc      (acc)
  );

  mock_mmu mmu_i (
    .clk             (clk),
    .reset           (reset),
    .cfg_en          (cfg_en),
    .cfg_boot_addr   (cfg_boot_addr),
    .cfg_boot_opcode (cfg_boot_opcode),
    .read_en         (read_en),
    .fetch           (fetch),
    .write_en        (write_en),
    .addr            (addr),
    .wdata           (wdata),
    .hit             (hit),
    .hit_data        (hit_data),
    .lookup_kind     (lookup_kind),
    .lookup_addr     (lookup_addr),
    .rdata           (rdata),
    .miss            (miss),
    .txn_count       (txn_count)
  );

  txn_table table_i (
    .clk         (clk),
    .reset       (reset),
    .load_en     (load_en),
    .load_index  (load_index),
    .load_kind   (load_kind),
    .load_addr   (load_addr),
    .load_data   (load_data),
    .count_en    (count_en),
    .load_count  (load_count),
    .lookup_kind (lookup_kind),
    .lookup_addr (lookup_addr),
    .hit         (hit),
    .hit_data    (hit_data)
  );

endmodule

`default_nettype wire

// File: tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_checker import cpu_pkg::*; (
  input  logic               clk,
  input  logic               reset,
  input  logic               start,
  input  logic               halted,
  input  word_t              acc,
  input  logic               write_seen,
  input  word_t              addr_out,
  input  word_t              data_out,
  input  logic               miss,
  input  logic [count_w-1:0] txn_count,
  input  txn_kind_e          t_kind [table_depth],
  input  word_t              t_addr [table_depth],
  input  word_t              t_data [table_depth],
  input  int                 t_count,
  input  word_t              boot_addr,
  input  word_t              boot_word,
  input  int                 test_id,
  output logic               test_done,
  output int                 error_count,
  output int                 tests_failed
);

  localparam int max_writes = 8;
  localparam int max_steps  = 64;  // far longer than any program here

  word_t exp_wa [max_writes];
  word_t exp_wd [max_writes];
  int    exp_writes;
  word_t exp_acc;
  int    exp_matched;
  int    exp_misses;
  int    writes;
  int    misses;
  int    errors;
  int    errors_total = 0;
  int    failed = 0;
  logic  running = 1'b0;
  logic  done_pulse = 1'b0;

  assign test_done    = done_pulse;
  assign error_count  = errors_total;
  assign tests_failed = failed;

  // scanning downward leaves the lowest matching index as the final answer
  function automatic logic find_entry(input txn_kind_e kind, input word_t a, output word_t d);
    logic found;
    found = 1'b0;
    d     = '0;
    for (int i = t_count - 1; i >= 0; i--) begin
      if (t_kind[i] == kind && t_addr[i] == a) begin
        found = 1'b1;
        d     = t_data[i];
      end
    end
    return found;
  endfunction

  // boot word first for reads, then the table, then zero or the fetch address
  function automatic word_t respond(input txn_kind_e kind, input word_t a,
                                    inout int matched, inout int missed);
    word_t d;
    logic  found;
    if (kind != kind_write && a == boot_addr) begin
      return boot_word;
    end
    found = find_entry(kind, a, d);
    if (found) begin
      matched++;
    end else begin
      missed++;
    end
    if (!found && kind == kind_fetch) begin
      d = a;
    end
    return d;
  endfunction

  // runs the loaded program on the instruction rules and collects what the bus should show
  function automatic void predict(output word_t wa [max_writes], output word_t wd [max_writes],
                                  output int nw, output word_t fin_acc,
                                  output int matched, output int missed);
    word_t pc;
    word_t ir;
    word_t operand;
    int    steps;
    logic  stop;
    pc      = '0;
    fin_acc = '0;
    nw      = 0;
    matched = 0;
    missed  = 0;
    steps   = 0;
    stop    = 1'b0;
    wa      = '{default: '0};
    wd      = '{default: '0};
    while (!stop && steps < max_steps) begin
      steps++;
      ir      = respond(kind_fetch, pc, matched, missed);
      operand = {4'd0, ir[27:0]};
      pc      = pc + 32'd1;
      case (opcode_e'(ir[31:28]))
        op_load: fin_acc = respond(kind_read, operand, matched, missed);
        op_add:  fin_acc = fin_acc + respond(kind_read, operand, matched, missed);
        op_store: begin
          void'(respond(kind_write, operand, matched, missed));
          if (nw < max_writes) begin
            wa[nw] = operand;
            wd[nw] = fin_acc;
          end
          nw++;
        end
        op_jump: pc = operand;
        op_halt: stop = 1'b1;
        default: stop = 1'b0;  // nop and unknown opcodes only step pc
      endcase
    end
  endfunction

  task automatic compare(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  always @(posedge clk) begin
    done_pulse = 1'b0;
    if (reset) begin
      running = 1'b0;
    end else if (!running) begin
      if (start) begin
        predict(exp_wa, exp_wd, exp_writes, exp_acc, exp_matched, exp_misses);
        writes  = 0;
        misses  = 0;
        errors  = 0;
        running = 1'b1;
      end
    end else begin
      if (miss) begin
        misses++;
      end
      if (write_seen) begin
        if (writes < exp_writes && writes < max_writes) begin
          compare("addr_out", addr_out, exp_wa[writes]);
          compare("data_out", data_out, exp_wd[writes]);
        end else begin
          $display("test %0d: unexpected write of %h to %h at %0t",
                   test_id, data_out, addr_out, $time);
          errors++;
        end
        writes++;
      end
      if (halted) begin
        compare("acc", acc, exp_acc);
        compare("txn_count", 32'(txn_count), 32'(exp_matched));
        compare("miss count", 32'(misses), 32'(exp_misses));
        if (writes != exp_writes) begin
          $display("test %0d: saw %0d writes where %0d were expected",
                   test_id, writes, exp_writes);
          errors++;
        end
        $display("test %0d %s: writes %0d, matched %0d, misses %0d", test_id,
                 (errors == 0) ? "passed" : "failed", writes, exp_matched, misses);
        errors_total += errors;
        if (errors != 0) begin
          failed++;
        end
        running    = 1'b0;
        done_pulse = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top import cpu_pkg::*; ();

  localparam int n_tests      = 6;
  localparam int prog_instrs  = 20;  // instructions executed over all six programs
  localparam int setup_cycles = 20;  // reset, table load, config and start of one test
  localparam int cycle_limit  = 2 * prog_instrs + n_tests * setup_cycles + 100;
  localparam word_t no_boot   = 32'h0fff_ffff;  // an address no program touches

  logic               clk = 1'b0;
  logic               reset;
  logic               load_en;
  logic [index_w-1:0] load_index;
  txn_kind_e          load_kind;
  word_t              load_addr;
  word_t              load_data;
  logic               count_en;
  logic [index_w:0]   load_count;
  logic               cfg_en;
  word_t              cfg_boot_addr;
  word_t              cfg_boot_opcode;
  logic               start;
  logic               halted;
  word_t              acc;
  logic               write_seen;
  word_t              addr_out;
  word_t              data_out;
  logic               miss;
  logic [count_w-1:0] txn_count;

  txn_kind_e t_kind [table_depth];
  word_t     t_addr [table_depth];
  word_t     t_data [table_depth];
  int        t_count = 0;
  word_t     boot_addr = no_boot;
  word_t     boot_word = '0;
  int        test_id = 0;
  logic      test_done;
  int        error_count;
  int        tests_failed;
  integer    seed = 32'h4a05;
  int        cycles = 0;

  cpu_system_top dut_i (.*);
  tb_checker     chk_i (.*);

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: a program did not reach halt within %0d cycles", cycle_limit);
      $display("=== FAIL ===");
      $finish;
    end
  end

  function automatic word_t encode(input opcode_e op, input word_t operand);
    return {op, operand[27:0]};
  endfunction

  task automatic new_test(input word_t b_addr, input word_t b_word);
    t_count   = 0;
    boot_addr = b_addr;
    boot_word = b_word;
    test_id   = test_id + 1;
  endtask

  task automatic add_entry(input txn_kind_e kind, input word_t a, input word_t d);
    t_kind[t_count] = kind;
    t_addr[t_count] = a;
    t_data[t_count] = d;
    t_count++;
  endtask

  // called on a falling edge, or at time zero for the first test
  task automatic run_test();
    reset = 1'b1;
    repeat (5) @(negedge clk);
    reset = 1'b0;
    for (int i = 0; i < t_count; i++) begin
      load_en    = 1'b1;
      load_index = i[index_w-1:0];
      load_kind  = t_kind[i];
      load_addr  = t_addr[i];
      load_data  = t_data[i];
      @(negedge clk);
    end
    load_en         = 1'b0;
    count_en        = 1'b1;
    load_count      = t_count[index_w:0];
    cfg_en          = 1'b1;
    cfg_boot_addr   = boot_addr;
    cfg_boot_opcode = boot_word;
    @(negedge clk);
    count_en = 1'b0;
    cfg_en   = 1'b0;
    start    = 1'b1;
    @(negedge clk);
    start = 1'b0;
    while (!test_done) @(negedge clk);
  endtask

  initial begin
    reset           = 1'b1;
    load_en         = 1'b0;
    load_index      = '0;
    load_kind       = kind_fetch;
    load_addr       = '0;
    load_data       = '0;
    count_en        = 1'b0;
    load_count      = '0;
    cfg_en          = 1'b0;
    cfg_boot_addr   = '0;
    cfg_boot_opcode = '0;
    start           = 1'b0;

    new_test(no_boot, '0);  // load a table value and store it back out
    add_entry(kind_fetch, 32'd0, encode(op_load, 32'h100));
    add_entry(kind_fetch, 32'd1, encode(op_store, 32'h200));
    add_entry(kind_fetch, 32'd2, encode(op_halt, 32'd0));
    add_entry(kind_read, 32'h100, $random(seed));
    add_entry(kind_write, 32'h200, '0);
    run_test();

    new_test(no_boot, '0);  // sum of three random words wraps at 32 bits
    add_entry(kind_fetch, 32'd0, encode(op_load, 32'h10));
    add_entry(kind_fetch, 32'd1, encode(op_add, 32'h11));
    add_entry(kind_fetch, 32'd2, encode(op_add, 32'h12));
    add_entry(kind_fetch, 32'd3, encode(op_halt, 32'd0));
    add_entry(kind_read, 32'h10, $random(seed));
    add_entry(kind_read, 32'h11, $random(seed) | 32'h8000_0000);  // top bits set so the sum carries out
    add_entry(kind_read, 32'h12, $random(seed) | 32'h8000_0000);
    run_test();

    // the boot word at 0 overrides the halt entry loaded for the same address
    new_test(32'd0, encode(op_jump, 32'd8));
    add_entry(kind_fetch, 32'd0, encode(op_halt, 32'd0));
    add_entry(kind_fetch, 32'd8, encode(op_load, 32'h20));
    add_entry(kind_fetch, 32'd9, encode(op_store, 32'h21));
    add_entry(kind_fetch, 32'd10, encode(op_halt, 32'd0));
    add_entry(kind_read, 32'h20, $random(seed));
    add_entry(kind_write, 32'h21, '0);
    run_test();

    new_test(no_boot, '0);  // data read without an entry gives zero
    add_entry(kind_fetch, 32'd0, encode(op_load, 32'h30));
    add_entry(kind_fetch, 32'd1, encode(op_store, 32'h31));
    add_entry(kind_fetch, 32'd2, encode(op_halt, 32'd0));
    add_entry(kind_write, 32'h31, '0);
    run_test();

    new_test(no_boot, '0);  // fetch at 1 has no entry and runs as a nop
    add_entry(kind_fetch, 32'd0, encode(op_load, 32'h40));
    add_entry(kind_fetch, 32'd2, encode(op_halt, 32'd0));
    add_entry(kind_read, 32'h40, $random(seed));
    run_test();

    new_test(no_boot, '0);  // two entries for 0x50, the first one must answer
    add_entry(kind_fetch, 32'd0, encode(op_load, 32'h50));
    add_entry(kind_fetch, 32'd1, encode(op_store, 32'h51));
    add_entry(kind_fetch, 32'd2, encode(op_halt, 32'd0));
    add_entry(kind_read, 32'h50, $random(seed));
    add_entry(kind_read, 32'h50, $random(seed));
    add_entry(kind_write, 32'h51, '0);
    run_test();

    $display("summary: %0d tests, %0d failed, %0d check errors",
             test_id, tests_failed, error_count);
    if (error_count == 0 && tests_failed == 0 && test_id == n_tests) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
cpu_pkg.sv
txn_table.sv
mock_mmu.sv
cpu_core.sv
cpu_system_top.sv
tb_checker.sv
tb_top.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_top
FILELIST  := list.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf $(OBJ_DIR)
